/* project.f */
source/ooo_pkg.sv
source/inst_decoder.sv
source/reg_rename_file.sv
source/reorder_buffer.sv
source/alu_exec.sv
source/rename_core.sv
tb/rename_core_assertions.sv
tb/tb_rename_core.sv

/* source/alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                flush,
    input  wire logic                disp_valid,
    input  wire ooo_pkg::dispatch_t  disp,
    output logic                     res_valid,
    output ooo_pkg::result_t         res
);

    logic [ooo_pkg::xlen-1:0] y;
    logic                     lt;

    assign lt = $signed(disp.a) < $signed(disp.b);

    always_comb begin
        case (disp.op)
            ooo_pkg::op_add: y = disp.a + disp.b;
            ooo_pkg::op_sub: y = disp.a - disp.b;
            ooo_pkg::op_and: y = disp.a & disp.b;
            ooo_pkg::op_or:  y = disp.a | disp.b;
            ooo_pkg::op_xor: y = disp.a ^ disp.b;
            ooo_pkg::op_slt: y = {{(ooo_pkg::xlen-1){1'b0}}, lt};
            default:         y = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= disp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid) begin
            res.tag  <= disp.tag;
            res.data <= y;
        end
    end

endmodule

`default_nettype wire

/* source/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          flush,
    input  wire logic          inst_valid,
    input  wire logic [31:0]   inst,
    output logic               dec_valid,
    output ooo_pkg::decoded_t  dec
);

    ooo_pkg::decoded_t dec_nxt;
    logic              supported;

    always_comb begin
        supported       = 1'b1;
        dec_nxt.op      = ooo_pkg::op_add;
        dec_nxt.rd      = inst[11:7];
        dec_nxt.rs1     = inst[19:15];
        dec_nxt.rs2     = inst[24:20];
        dec_nxt.imm     = {{20{inst[31]}}, inst[31:20]};
        dec_nxt.use_imm = 1'b0;
        case (inst[6:0])
            ooo_pkg::opc_op: begin
                // funct7 and funct3 together pick the R-type operation
                case ({inst[31:25], inst[14:12]})
                    10'b0000000_000: dec_nxt.op = ooo_pkg::op_add;
                    10'b0100000_000: dec_nxt.op = ooo_pkg::op_sub;
                    10'b0000000_111: dec_nxt.op = ooo_pkg::op_and;
                    10'b0000000_110: dec_nxt.op = ooo_pkg::op_or;
                    10'b0000000_100: dec_nxt.op = ooo_pkg::op_xor;
                    10'b0000000_010: dec_nxt.op = ooo_pkg::op_slt;
                    default:         supported  = 1'b0;
                endcase
            end
            ooo_pkg::opc_op_imm: begin
                dec_nxt.rs2     = '0;
                dec_nxt.use_imm = 1'b1;
                case (inst[14:12])
                    3'b000:  dec_nxt.op = ooo_pkg::op_add;
                    3'b111:  dec_nxt.op = ooo_pkg::op_and;
                    3'b110:  dec_nxt.op = ooo_pkg::op_or;
                    3'b100:  dec_nxt.op = ooo_pkg::op_xor;
                    default: supported  = 1'b0;
                endcase
            end
            default: supported = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= inst_valid && supported;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            dec <= dec_nxt;
        end
    end

endmodule

`default_nettype wire

/* source/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    localparam int xlen       = 32;
    localparam int num_regs   = 32;
    localparam int reg_addr_w = 5;
    localparam int rob_depth  = 8;
    localparam int rob_ptr_w  = 3;
    // tag 0 is reserved for "not renamed", so entry i carries tag i+1
    localparam int tag_w      = 4;

    // major opcodes of the two supported instruction groups
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt
    } alu_op_e;

    typedef struct packed {
        alu_op_e               op;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       imm;
        logic                  use_imm;
    } decoded_t;

    typedef struct packed {
        alu_op_e          op;
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  a;
        logic [xlen-1:0]  b;
    } dispatch_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
    } result_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [tag_w-1:0]      tag;
        logic [xlen-1:0]       data;
    } rob_commit_t;

endpackage

`default_nettype wire

/* source/reg_rename_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_rename_file (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            flush,
    input  wire logic                            dec_valid,
    input  wire ooo_pkg::decoded_t               dec,
    input  wire logic [ooo_pkg::tag_w-1:0]       alloc_tag,
    input  wire logic                            look_done1,
    input  wire logic [ooo_pkg::xlen-1:0]        look_data1,
    input  wire logic                            look_done2,
    input  wire logic [ooo_pkg::xlen-1:0]        look_data2,
    input  wire logic                            res_valid,
    input  wire ooo_pkg::result_t                res,
    input  wire logic                            commit_valid,
    input  wire ooo_pkg::rob_commit_t            commit,
    output logic                                 disp_valid,
    output ooo_pkg::dispatch_t                   disp,
    output logic                                 alloc_valid,
    output logic [ooo_pkg::reg_addr_w-1:0]       alloc_rd,
    output logic [ooo_pkg::tag_w-1:0]            look_tag1,
    output logic [ooo_pkg::tag_w-1:0]            look_tag2
);

    logic [ooo_pkg::xlen-1:0]  data_q [ooo_pkg::num_regs];
    logic [ooo_pkg::tag_w-1:0] tag_q  [ooo_pkg::num_regs];
    logic [ooo_pkg::xlen:0]    sel1;
    logic [ooo_pkg::xlen:0]    sel2;
    ooo_pkg::dispatch_t        disp_q;
    logic                      pend_a;
    logic                      pend_b;

    // msb of the result is set when the producer sits in the ALU right now,
    // its value then shows up on res one cycle later
    function automatic logic [ooo_pkg::xlen:0] pick(
        input logic [ooo_pkg::reg_addr_w-1:0] rs,
        input logic [ooo_pkg::tag_w-1:0]      tag,
        input logic [ooo_pkg::xlen-1:0]       arch,
        input logic                           done,
        input logic [ooo_pkg::xlen-1:0]       rob_data,
        input logic                           hit_valid,
        input ooo_pkg::result_t               hit
    );
        if (rs == '0) begin
            return '0;
        end else if (tag == '0) begin
            return {1'b0, arch};
        end else if (hit_valid && hit.tag == tag) begin
            return {1'b0, hit.data};
        end else if (done) begin
            return {1'b0, rob_data};
        end
        return {1'b1, rob_data};
    endfunction

    assign look_tag1   = tag_q[dec.rs1];
    assign look_tag2   = tag_q[dec.rs2];
    assign alloc_valid = dec_valid && !flush;
    assign alloc_rd    = dec.rd;

    assign sel1 = pick(dec.rs1, look_tag1, data_q[dec.rs1], look_done1, look_data1,
                       res_valid, res);
    assign sel2 = dec.use_imm ? {1'b0, dec.imm}
                              : pick(dec.rs2, look_tag2, data_q[dec.rs2], look_done2,
                                     look_data2, res_valid, res);

    // late bypass for a back-to-back dependency
    always_comb begin
        disp = disp_q;
        if (pend_a) begin
            disp.a = res.data;
        end
        if (pend_b) begin
            disp.b = res.data;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            disp_q.op  <= dec.op;
            disp_q.tag <= alloc_tag;
            disp_q.a   <= sel1[ooo_pkg::xlen-1:0];
            disp_q.b   <= sel2[ooo_pkg::xlen-1:0];
            pend_a     <= sel1[ooo_pkg::xlen];
            pend_b     <= sel2[ooo_pkg::xlen];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            disp_valid <= 1'b0;
            for (int i = 0; i < ooo_pkg::num_regs; i++) begin
                data_q[i] <= '0;
                tag_q[i]  <= '0;
            end
        end else begin
            if (commit_valid && commit.rd != '0) begin
                data_q[commit.rd] <= commit.data;
                if (tag_q[commit.rd] == commit.tag) begin
                    tag_q[commit.rd] <= '0;
                end
            end
            // a rename on the same edge overrides the clear above
            if (flush) begin
                disp_valid <= 1'b0;
                for (int i = 0; i < ooo_pkg::num_regs; i++) begin
                    tag_q[i] <= '0;
                end
            end else begin
                disp_valid <= dec_valid;
                if (dec_valid && dec.rd != '0) begin
                    tag_q[dec.rd] <= alloc_tag;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/rename_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              flush,
    input  wire logic              inst_valid,
    input  wire logic [31:0]       inst,
    output logic                   commit_valid,
    output ooo_pkg::rob_commit_t   commit
);

    logic                           dec_valid;
    ooo_pkg::decoded_t              dec;
    logic                           disp_valid;
    ooo_pkg::dispatch_t             disp;
    logic                           alloc_valid;
    logic [ooo_pkg::reg_addr_w-1:0] alloc_rd;
    logic [ooo_pkg::tag_w-1:0]      alloc_tag;
    logic [ooo_pkg::tag_w-1:0]      look_tag1;
    logic [ooo_pkg::tag_w-1:0]      look_tag2;
    logic                           look_done1;
    logic                           look_done2;
    logic [ooo_pkg::xlen-1:0]       look_data1;
    logic [ooo_pkg::xlen-1:0]       look_data2;
    logic                           res_valid;
    ooo_pkg::result_t               res;

    inst_decoder u_decoder (
        .clk(clk), .rst(rst), .flush(flush),
        .inst_valid(inst_valid), .inst(inst),
        .dec_valid(dec_valid), .dec(dec)
    );

    reg_rename_file u_regfile (
        .clk(clk), .rst(rst), .flush(flush),
        .dec_valid(dec_valid), .dec(dec), .alloc_tag(alloc_tag),
        .look_done1(look_done1), .look_data1(look_data1),
        .look_done2(look_done2), .look_data2(look_data2),
        .res_valid(res_valid), .res(res),
        .commit_valid(commit_valid), .commit(commit),
        .disp_valid(disp_valid), .disp(disp),
        .alloc_valid(alloc_valid), .alloc_rd(alloc_rd),
        .look_tag1(look_tag1), .look_tag2(look_tag2)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst(rst), .flush(flush),
        .alloc_valid(alloc_valid), .alloc_rd(alloc_rd),
        .res_valid(res_valid), .res(res),
        .look_tag1(look_tag1), .look_tag2(look_tag2),
        .alloc_tag(alloc_tag),
        .look_done1(look_done1), .look_data1(look_data1),
        .look_done2(look_done2), .look_data2(look_data2),
        .commit_valid(commit_valid), .commit(commit)
    );

    alu_exec u_alu (
        .clk(clk), .rst(rst), .flush(flush),
        .disp_valid(disp_valid), .disp(disp),
        .res_valid(res_valid), .res(res)
    );

endmodule

`default_nettype wire

/* source/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            flush,
    input  wire logic                            alloc_valid,
    input  wire logic [ooo_pkg::reg_addr_w-1:0]  alloc_rd,
    input  wire logic                            res_valid,
    input  wire ooo_pkg::result_t                res,
    input  wire logic [ooo_pkg::tag_w-1:0]       look_tag1,
    input  wire logic [ooo_pkg::tag_w-1:0]       look_tag2,
    output logic [ooo_pkg::tag_w-1:0]            alloc_tag,
    output logic                                 look_done1,
    output logic [ooo_pkg::xlen-1:0]             look_data1,
    output logic                                 look_done2,
    output logic [ooo_pkg::xlen-1:0]             look_data2,
    output logic                                 commit_valid,
    output ooo_pkg::rob_commit_t                 commit
);

    logic [ooo_pkg::reg_addr_w-1:0] rd_q   [ooo_pkg::rob_depth];
    logic [ooo_pkg::xlen-1:0]       data_q [ooo_pkg::rob_depth];
    logic [ooo_pkg::rob_depth-1:0]  done_q;
    logic [ooo_pkg::rob_ptr_w-1:0]  head_q;
    logic [ooo_pkg::rob_ptr_w-1:0]  tail_q;
    logic [ooo_pkg::tag_w-1:0]      head_tag;
    logic [ooo_pkg::rob_ptr_w-1:0]  res_idx;
    logic [ooo_pkg::rob_ptr_w-1:0]  look_idx1;
    logic [ooo_pkg::rob_ptr_w-1:0]  look_idx2;
    logic                           head_hit;
    logic                           head_ready;

    function automatic logic [ooo_pkg::rob_ptr_w-1:0] tag_to_idx(
        input logic [ooo_pkg::tag_w-1:0] tag
    );
        logic [ooo_pkg::tag_w-1:0] t;
        t = tag - 1'b1;
        return t[ooo_pkg::rob_ptr_w-1:0];
    endfunction

    assign alloc_tag = {1'b0, tail_q} + 1'b1;
    assign head_tag  = {1'b0, head_q} + 1'b1;
    assign res_idx   = tag_to_idx(res.tag);
    assign look_idx1 = tag_to_idx(look_tag1);
    assign look_idx2 = tag_to_idx(look_tag2);

    // done bits stay set after commit so that late readers still find the value
    assign look_done1 = (look_tag1 != '0) && done_q[look_idx1];
    assign look_data1 = data_q[look_idx1];
    assign look_done2 = (look_tag2 != '0) && done_q[look_idx2];
    assign look_data2 = data_q[look_idx2];

    // the head may retire in the same cycle its result arrives
    assign head_hit   = res_valid && res.tag == head_tag;
    assign head_ready = (head_q != tail_q) && (done_q[head_q] || head_hit);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_q       <= '0;
            tail_q       <= '0;
            done_q       <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (alloc_valid) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (res_valid) begin
                done_q[res_idx] <= 1'b1;
            end
            commit_valid <= head_ready;
            if (head_ready) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            rd_q[tail_q] <= alloc_rd;
        end
        if (res_valid) begin
            data_q[res_idx] <= res.data;
        end
        if (head_ready) begin
            commit.rd   <= rd_q[head_q];
            commit.tag  <= head_tag;
            commit.data <= done_q[head_q] ? data_q[head_q] : res.data;
        end
    end

endmodule

`default_nettype wire

/* tb/rename_core_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rename_core_assertions (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  flush,
    input wire logic                  commit_valid,
    input wire ooo_pkg::rob_commit_t  commit
);

    int                        fail_count = 0;
    logic [ooo_pkg::tag_w-1:0] next_tag;

    // commits retire the rob entries in order, so the tag walks 1..rob_depth
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            next_tag <= 1;
        end else if (commit_valid) begin
            if (commit.tag == ooo_pkg::rob_depth) begin
                next_tag <= 1;
            end else begin
                next_tag <= commit.tag + 1'b1;
            end
        end
    end

    no_commit_after_flush: assert property (
        @(posedge clk) disable iff (rst) flush |=> !commit_valid
    ) else begin
        fail_count = fail_count + 1;
        $error("commit_valid high in the cycle after a flush");
    end

    tag_in_order: assert property (
        @(posedge clk) disable iff (rst) commit_valid |-> commit.tag == next_tag
    ) else begin
        fail_count = fail_count + 1;
        $error("commit tag %0d, expected %0d", commit.tag, next_tag);
    end

    tag_not_zero: assert property (
        @(posedge clk) disable iff (rst) commit_valid |-> commit.tag != '0
    ) else begin
        fail_count = fail_count + 1;
        $error("commit with tag 0");
    end

endmodule

`default_nettype wire

/* tb/tb_rename_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core;

    localparam int random_count    = 300;
    localparam int directed_cycles = 200;
    // a random instruction takes at most two cycles, one issue and one idle
    localparam int stim_cycles     = 3 + directed_cycles + 2 * random_count;
    localparam int watchdog_ns     = stim_cycles * 8 + 400;

    typedef struct packed {
        logic [31:0] due;
        logic [31:0] ins;
    } exp_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 flush;
    logic                 inst_valid;
    logic [31:0]          inst;
    logic                 commit_valid;
    ooo_pkg::rob_commit_t commit;

    logic [31:0] cyc = '0;
    logic [15:0] lfsr = 16'd88;
    logic [31:0] model_regs [32];
    exp_t        exp_q [$];
    int          commits = 0;

    rename_core u_rename_core (
        .clk(clk), .rst(rst), .flush(flush),
        .inst_valid(inst_valid), .inst(inst),
        .commit_valid(commit_valid), .commit(commit)
    );

    bind rename_core rename_core_assertions u_assertions (
        .clk(clk), .rst(rst), .flush(flush),
        .commit_valid(commit_valid), .commit(commit)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic is_supported(input logic [31:0] ins);
        if (ins[6:0] == 7'b0110011) begin
            return (ins[31:25] == 7'h00 && ins[14:12] inside {3'd0, 3'd2, 3'd4, 3'd6, 3'd7})
                || (ins[31:25] == 7'h20 && ins[14:12] == 3'd0);
        end
        if (ins[6:0] == 7'b0010011) begin
            return ins[14:12] inside {3'd0, 3'd4, 3'd6, 3'd7};
        end
        return 1'b0;
    endfunction

    // executes one instruction on the model registers and returns its result
    function automatic logic [31:0] ref_exec(input logic [31:0] ins);
        logic [31:0] a;
        logic [31:0] b;
        a = model_regs[ins[19:15]];
        if (ins[6:0] == 7'b0010011) begin
            b = {{20{ins[31]}}, ins[31:20]};
        end else begin
            b = model_regs[ins[24:20]];
        end
        case (ins[14:12])
            3'd0: return (ins[6:0] == 7'b0110011 && ins[30]) ? a - b : a + b;
            3'd7: return a & b;
            3'd6: return a | b;
            3'd4: return a ^ b;
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            default: return 'x;
        endcase
    endfunction

    function automatic logic [31:0] random_inst(input logic [3:0] sel, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2,
                                                input logic [11:0] imm);
        case (sel)
            4'd0: return r_type(7'h00, 3'd0, rd, rs1, rs2);
            4'd1: return r_type(7'h20, 3'd0, rd, rs1, rs2);
            4'd2: return r_type(7'h00, 3'd7, rd, rs1, rs2);
            4'd3: return r_type(7'h00, 3'd6, rd, rs1, rs2);
            4'd4: return r_type(7'h00, 3'd4, rd, rs1, rs2);
            4'd5: return r_type(7'h00, 3'd2, rd, rs1, rs2);
            4'd7: return i_type(3'd7, rd, rs1, imm);
            4'd8: return i_type(3'd6, rd, rs1, imm);
            4'd9: return i_type(3'd4, rd, rs1, imm);
            // slti is not in the supported set
            4'd10: return i_type(3'd2, rd, rs1, imm);
            default: return i_type(3'd0, rd, rs1, imm);
        endcase
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "commit mismatch");
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic issue(input logic [31:0] ins);
        exp_t e;
        inst_valid = 1'b1;
        inst = ins;
        if (is_supported(ins)) begin
            e.due = cyc + 4;
            e.ins = ins;
            exp_q.push_back(e);
        end
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // everything issued in the three slots before the flush is lost
    task automatic flush_pipeline(input logic [31:0] ins);
        flush = 1'b1;
        inst_valid = 1'b1;
        inst = ins;
        while (exp_q.size() != 0 && exp_q[$].due > cyc) begin
            void'(exp_q.pop_back());
        end
        @(negedge clk);
        flush = 1'b0;
        inst_valid = 1'b0;
    endtask

    always @(negedge clk) begin : compare_commits
        exp_t        e;
        logic [31:0] val;
        if (!rst) begin
            if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
                e = exp_q.pop_front();
                val = ref_exec(e.ins);
                if (e.ins[11:7] != 5'd0) begin
                    model_regs[e.ins[11:7]] = val;
                end
                check(commit_valid, 1'b1, "commit_valid");
                check(commit.rd, e.ins[11:7], "commit rd");
                check(commit.data, val, "commit data");
                commits++;
            end else begin
                check(commit_valid, 1'b0, "commit_valid");
            end
        end
    end

    always @(negedge clk) begin
        if (u_rename_core.u_assertions.fail_count != 0) begin
            $display("assertion on the commit port failed at %0t ns", $time);
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns with %0d commits pending", watchdog_ns,
                 exp_q.size());
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] sel;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic [31:0] gap;
        rst = 1'b1;
        flush = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // independent instructions
        issue(i_type(3'd0, 5'd1, 5'd0, 12'h123));
        issue(i_type(3'd0, 5'd2, 5'd0, 12'hfaa));
        issue(i_type(3'd0, 5'd3, 5'd0, 12'h7ff));
        issue(i_type(3'd0, 5'd4, 5'd0, 12'hfff));
        idle(4);
        issue(r_type(7'h00, 3'd0, 5'd5, 5'd1, 5'd2));
        issue(r_type(7'h20, 3'd0, 5'd6, 5'd3, 5'd4));
        issue(r_type(7'h00, 3'd7, 5'd7, 5'd1, 5'd3));
        issue(r_type(7'h00, 3'd6, 5'd8, 5'd2, 5'd4));
        issue(r_type(7'h00, 3'd4, 5'd9, 5'd1, 5'd4));
        issue(r_type(7'h00, 3'd2, 5'd10, 5'd2, 5'd1));
        issue(i_type(3'd4, 5'd11, 5'd3, 12'h0f0));
        issue(i_type(3'd6, 5'd12, 5'd1, 12'h800));
        issue(i_type(3'd7, 5'd13, 5'd4, 12'h5a5));
        idle(4);

        // back-to-back and distance-two dependencies
        issue(i_type(3'd0, 5'd14, 5'd1, 12'h005));
        issue(r_type(7'h00, 3'd0, 5'd15, 5'd14, 5'd14));
        issue(r_type(7'h20, 3'd0, 5'd16, 5'd15, 5'd14));
        issue(i_type(3'd0, 5'd17, 5'd2, 12'hffd));
        issue(i_type(3'd4, 5'd18, 5'd3, 12'h055));
        issue(r_type(7'h00, 3'd7, 5'd19, 5'd17, 5'd2));
        issue(r_type(7'h00, 3'd6, 5'd19, 5'd19, 5'd17));
        issue(r_type(7'h00, 3'd2, 5'd14, 5'd4, 5'd17));
        idle(4);

        // x0 as destination
        issue(i_type(3'd0, 5'd0, 5'd1, 12'h009));
        issue(r_type(7'h00, 3'd0, 5'd26, 5'd0, 5'd1));
        issue(r_type(7'h00, 3'd6, 5'd0, 5'd2, 5'd3));
        issue(r_type(7'h00, 3'd6, 5'd27, 5'd0, 5'd0));
        idle(4);

        // unsupported encodings mixed with dependent work
        issue(32'h0000_2083);
        issue(r_type(7'h01, 3'd0, 5'd28, 5'd1, 5'd2));
        issue(r_type(7'h00, 3'd0, 5'd28, 5'd1, 5'd2));
        issue(i_type(3'd2, 5'd28, 5'd1, 12'h010));
        issue(i_type(3'd0, 5'd29, 5'd28, 12'h001));
        issue(r_type(7'h00, 3'd1, 5'd29, 5'd1, 5'd2));
        idle(4);

        // flush with four instructions in flight
        issue(i_type(3'd0, 5'd20, 5'd0, 12'h064));
        issue(i_type(3'd0, 5'd21, 5'd0, 12'h0c8));
        issue(r_type(7'h00, 3'd0, 5'd20, 5'd20, 5'd20));
        issue(i_type(3'd0, 5'd22, 5'd21, 12'h001));
        flush_pipeline(i_type(3'd0, 5'd23, 5'd0, 12'h007));
        issue(r_type(7'h00, 3'd0, 5'd24, 5'd20, 5'd21));
        issue(r_type(7'h00, 3'd0, 5'd25, 5'd22, 5'd23));
        idle(4);

        // random stream over x0..x7 so that dependencies are frequent
        for (int n = 0; n < random_count; n++) begin
            rand_bits(4, sel);
            rand_bits(3, rd);
            rand_bits(3, rs1);
            rand_bits(3, rs2);
            rand_bits(12, imm);
            rand_bits(2, gap);
            issue(random_inst(sel[3:0], rd[4:0], rs1[4:0], rs2[4:0], imm[11:0]));
            if (gap[1:0] == 2'b00) begin
                idle(1);
            end
        end

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle(4);
        if (u_rename_core.u_assertions.fail_count == 0) begin
            $display("%0d commits checked", commits);
            $display("TEST OK");
            $finish;
        end else begin
            $display("%0d assertion failures on the commit port",
                     u_rename_core.u_assertions.fail_count);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire
